/* dual_issue_pkg.sv */
`default_nettype none

package dual_issue_pkg;

  // Datapath widths
  localparam int INSTR_W         = 32;
  localparam int RES_W           = 16;
  localparam int SEQ_W           = 8;
  localparam int FIFO_DEPTH_LOG2 = 3;

  // Instruction field widths
  localparam int OP_W    = 4;
  localparam int OPND_W  = 14;
  localparam int SHAMT_W = 4;
  localparam int IMM_W   = 10;

  // Top opcode bit marks the immediate form
  localparam logic [OP_W-1:0] OP_ADD  = 4'h0;
  localparam logic [OP_W-1:0] OP_SUB  = 4'h1;
  localparam logic [OP_W-1:0] OP_AND  = 4'h2;
  localparam logic [OP_W-1:0] OP_XOR  = 4'h3;
  localparam logic [OP_W-1:0] OP_ADDI = 4'h8;
  localparam logic [OP_W-1:0] OP_SHLI = 4'h9;

  typedef struct packed {
    logic [OP_W-1:0]   op;
    logic [OPND_W-1:0] a;
    logic [OPND_W-1:0] b;
  } instr_r_s;

  typedef struct packed {
    logic [OP_W-1:0]    op;
    logic [OPND_W-1:0]  a;
    logic [SHAMT_W-1:0] shamt;
    logic [IMM_W-1:0]   imm;
  } instr_i_s;

  // Same word, register or immediate view
  typedef union packed {
    instr_r_s r;
    instr_i_s i;
  } instr_u;

endpackage

`default_nettype wire

/* open_fifo4.sv */
`timescale 1ns/10ps
`default_nettype none

module open_fifo4 #(
  parameter int DWIDTH = 32
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               push,
  input  wire               pop,
  input  wire  [DWIDTH-1:0] in_data,
  output logic [DWIDTH-1:0] out_data,
  output logic              full,
  output logic              empty,
  output logic              half_full,
  output logic [DWIDTH-1:0] d0,
  output logic [DWIDTH-1:0] d1,
  output logic [DWIDTH-1:0] d2,
  output logic [DWIDTH-1:0] d3,
  output logic [1:0]        nxt_rd_ptr,
  output logic [3:0]        d_valid
);

  logic [DWIDTH-1:0] mem [4];
  logic [1:0]        wr_ptr;
  logic [1:0]        rd_ptr;
  logic [2:0]        count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      d_valid <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      count <= count + {2'b00, push} - {2'b00, pop};
      // Pop and push never hit the same slot in a legal cycle
      if (pop) begin
        d_valid[rd_ptr] <= 1'b0;
      end
      if (push) begin
        d_valid[wr_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Head word straight off the flops
  assign out_data = mem[rd_ptr];

  assign full      = (count == 3'd4);
  assign empty     = (count == 3'd0);
  assign half_full = (count >= 3'd2);

  assign d0 = mem[0];
  assign d1 = mem[1];
  assign d2 = mem[2];
  assign d3 = mem[3];

  assign nxt_rd_ptr = rd_ptr;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("open_fifo4: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
    else $error("open_fifo4: pop while empty");

endmodule

`default_nettype wire

/* open_fifo8_2w2r.sv */
`timescale 1ns/10ps
`default_nettype none

module open_fifo8_2w2r
  import dual_issue_pkg::*;
#(
  parameter int DWIDTH = 32
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        push0,
  input  wire  [DWIDTH-1:0]          in_data0,
  input  wire                        push1,
  input  wire  [DWIDTH-1:0]          in_data1,
  input  wire                        pop0,
  input  wire                        pop1,
  output logic [DWIDTH-1:0]          out_data0,
  output logic [DWIDTH-1:0]          out_data1,
  output logic                       fifo_half_full,
  output logic                       fifo_full,
  output logic                       fifo_1left_to_full,
  output logic                       fifo_empty,
  output logic                       fifo_1left_to_empty,
  output logic [DWIDTH-1:0]          d0,
  output logic [DWIDTH-1:0]          d1,
  output logic [DWIDTH-1:0]          d2,
  output logic [DWIDTH-1:0]          d3,
  output logic [DWIDTH-1:0]          d4,
  output logic [DWIDTH-1:0]          d5,
  output logic [DWIDTH-1:0]          d6,
  output logic [DWIDTH-1:0]          d7,
  output logic [FIFO_DEPTH_LOG2-1:0] d_ptr,
  output logic [7:0]                 d_valid
);

  logic              push_swap;
  logic              pop_swap;
  logic              push_even;
  logic              push_odd;
  logic [DWIDTH-1:0] data_even;
  logic [DWIDTH-1:0] data_odd;
  logic              pop_even;
  logic              pop_odd;
  logic [DWIDTH-1:0] out_even;
  logic [DWIDTH-1:0] out_odd;
  logic              full_even;
  logic              full_odd;
  logic              empty_even;
  logic              empty_odd;
  logic              half_even;
  logic              half_odd;
  logic [1:0]        ptr_even;
  logic [1:0]        ptr_odd;
  logic [3:0]        valid_even;
  logic [3:0]        valid_odd;

  // A single push or pop flips which bank is next
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_swap <= 1'b0;
      pop_swap  <= 1'b0;
    end else begin
      if (push0 && !push1) begin
        push_swap <= !push_swap;
      end
      if (pop0 && !pop1) begin
        pop_swap <= !pop_swap;
      end
    end
  end

  assign push_even = push_swap ? push1 : push0;
  assign push_odd  = push_swap ? push0 : push1;
  assign data_even = push_swap ? in_data1 : in_data0;
  assign data_odd  = push_swap ? in_data0 : in_data1;

  assign pop_even  = pop_swap ? pop1 : pop0;
  assign pop_odd   = pop_swap ? pop0 : pop1;
  assign out_data0 = pop_swap ? out_odd : out_even;
  assign out_data1 = pop_swap ? out_even : out_odd;

  // Banks never differ by more than one entry
  assign fifo_full           = full_even && full_odd;
  assign fifo_1left_to_full  = full_even ^ full_odd;
  assign fifo_half_full      = half_even && half_odd;
  assign fifo_empty          = empty_even && empty_odd;
  assign fifo_1left_to_empty = empty_even ^ empty_odd;

  assign d_ptr   = pop_swap ? {ptr_odd, 1'b1} : {ptr_even, 1'b0};
  assign d_valid = {valid_odd[3], valid_even[3], valid_odd[2], valid_even[2],
                    valid_odd[1], valid_even[1], valid_odd[0], valid_even[0]};

  // Even bank holds global entries 0, 2, 4, 6
  open_fifo4 #(.DWIDTH(DWIDTH)) fifo_even (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push_even),
    .pop       (pop_even),
    .in_data   (data_even),
    .out_data  (out_even),
    .full      (full_even),
    .empty     (empty_even),
    .half_full (half_even),
    .d0        (d0),
    .d1        (d2),
    .d2        (d4),
    .d3        (d6),
    .nxt_rd_ptr(ptr_even),
    .d_valid   (valid_even)
  );

  open_fifo4 #(.DWIDTH(DWIDTH)) fifo_odd (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push_odd),
    .pop       (pop_odd),
    .in_data   (data_odd),
    .out_data  (out_odd),
    .full      (full_odd),
    .empty     (empty_odd),
    .half_full (half_odd),
    .d0        (d1),
    .d1        (d3),
    .d2        (d5),
    .d3        (d7),
    .nxt_rd_ptr(ptr_odd),
    .d_valid   (valid_odd)
  );

  a_push_pair: assert property (@(posedge clk) disable iff (!rst_n) push1 |-> push0)
    else $error("open_fifo8_2w2r: push1 without push0");

endmodule

`default_nettype wire

/* issue_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_decode
  import dual_issue_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 hold,
  input  wire                 fifo_empty,
  input  wire                 fifo_1left_to_empty,
  input  wire  [INSTR_W-1:0]  head0,
  input  wire  [INSTR_W-1:0]  head1,
  output logic                pop0,
  output logic                pop1,
  output logic                dec_valid0,
  output logic [OP_W-1:0]     dec_op0,
  output logic [OPND_W-1:0]   dec_a0,
  output logic [OPND_W-1:0]   dec_b0,
  output logic [IMM_W-1:0]    dec_imm0,
  output logic [SHAMT_W-1:0]  dec_shamt0,
  output logic                dec_valid1,
  output logic [OP_W-1:0]     dec_op1,
  output logic [OPND_W-1:0]   dec_a1,
  output logic [OPND_W-1:0]   dec_b1,
  output logic [IMM_W-1:0]    dec_imm1,
  output logic [SHAMT_W-1:0]  dec_shamt1
);

  instr_u             head_w [2];
  logic [1:0]         fire;
  logic [1:0]         valid_q;
  logic [OP_W-1:0]    op_q    [2];
  logic [OPND_W-1:0]  a_q     [2];
  logic [OPND_W-1:0]  b_q     [2];
  logic [IMM_W-1:0]   imm_q   [2];
  logic [SHAMT_W-1:0] shamt_q [2];

  // Two when two or more present, one when exactly one
  assign pop0 = !hold && !fifo_empty;
  assign pop1 = pop0 && !fifo_1left_to_empty;

  assign fire      = {pop1, pop0};
  assign head_w[0] = head0;
  assign head_w[1] = head1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < 2; l++) begin
      if (fire[l]) begin
        op_q[l] <= head_w[l].r.op;
        a_q[l]  <= head_w[l].r.a;
        if (head_w[l].r.op[OP_W-1]) begin
          b_q[l]     <= '0;
          imm_q[l]   <= head_w[l].i.imm;
          shamt_q[l] <= head_w[l].i.shamt;
        end else begin
          b_q[l]     <= head_w[l].r.b;
          imm_q[l]   <= '0;
          shamt_q[l] <= '0;
        end
      end
    end
  end

  // Lane 0 is always the older word
  assign dec_valid0 = valid_q[0];
  assign dec_op0    = op_q[0];
  assign dec_a0     = a_q[0];
  assign dec_b0     = b_q[0];
  assign dec_imm0   = imm_q[0];
  assign dec_shamt0 = shamt_q[0];
  assign dec_valid1 = valid_q[1];
  assign dec_op1    = op_q[1];
  assign dec_a1     = a_q[1];
  assign dec_b1     = b_q[1];
  assign dec_imm1   = imm_q[1];
  assign dec_shamt1 = shamt_q[1];

  a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(fifo_empty && fifo_1left_to_empty))
    else $error("issue_decode: FIFO empty and one-left flags both set");

endmodule

`default_nettype wire

/* alu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_execute
  import dual_issue_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 dec_valid0,
  input  wire  [OP_W-1:0]     dec_op0,
  input  wire  [OPND_W-1:0]   dec_a0,
  input  wire  [OPND_W-1:0]   dec_b0,
  input  wire  [IMM_W-1:0]    dec_imm0,
  input  wire  [SHAMT_W-1:0]  dec_shamt0,
  input  wire                 dec_valid1,
  input  wire  [OP_W-1:0]     dec_op1,
  input  wire  [OPND_W-1:0]   dec_a1,
  input  wire  [OPND_W-1:0]   dec_b1,
  input  wire  [IMM_W-1:0]    dec_imm1,
  input  wire  [SHAMT_W-1:0]  dec_shamt1,
  output logic                res_valid0,
  output logic [RES_W-1:0]    res_data0,
  output logic                res_valid1,
  output logic [RES_W-1:0]    res_data1
);

  // Register ops work at operand width, then zero-extend
  function automatic logic [RES_W-1:0] alu_op(
    input logic [OP_W-1:0]    op,
    input logic [OPND_W-1:0]  a,
    input logic [OPND_W-1:0]  b,
    input logic [IMM_W-1:0]   imm,
    input logic [SHAMT_W-1:0] shamt
  );
    logic [OPND_W-1:0] r;
    logic [RES_W-1:0]  sum;
    r   = '0;
    sum = RES_W'(a) + RES_W'(imm);
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_XOR:  r = a ^ b;
      default: r = '0;
    endcase
    case (op)
      OP_ADDI: alu_op = sum;
      OP_SHLI: alu_op = sum << shamt;
      default: alu_op = RES_W'(r);
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid0 <= 1'b0;
      res_valid1 <= 1'b0;
    end else begin
      res_valid0 <= dec_valid0;
      res_valid1 <= dec_valid1;
    end
  end

  always_ff @(posedge clk) begin
    res_data0 <= alu_op(dec_op0, dec_a0, dec_b0, dec_imm0, dec_shamt0);
    res_data1 <= alu_op(dec_op1, dec_a1, dec_b1, dec_imm1, dec_shamt1);
  end

endmodule

`default_nettype wire

/* result_retire.sv */
`timescale 1ns/10ps
`default_nettype none

module result_retire
  import dual_issue_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               res_valid0,
  input  wire  [RES_W-1:0]  res_data0,
  input  wire               res_valid1,
  input  wire  [RES_W-1:0]  res_data1,
  output logic              ret_valid0,
  output logic [RES_W-1:0]  ret_data0,
  output logic [SEQ_W-1:0]  ret_seq0,
  output logic              ret_valid1,
  output logic [RES_W-1:0]  ret_data1,
  output logic [SEQ_W-1:0]  ret_seq1
);

  logic [SEQ_W-1:0] seq;

  // Wraps at 256, lane 1 never valid alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq        <= '0;
      ret_valid0 <= 1'b0;
      ret_valid1 <= 1'b0;
    end else begin
      seq        <= seq + SEQ_W'(res_valid0) + SEQ_W'(res_valid1);
      ret_valid0 <= res_valid0;
      ret_valid1 <= res_valid1;
    end
  end

  always_ff @(posedge clk) begin
    ret_data0 <= res_data0;
    ret_data1 <= res_data1;
    ret_seq0  <= seq;
    ret_seq1  <= seq + SEQ_W'(1);
  end

  a_res_order: assert property (@(posedge clk) disable iff (!rst_n) res_valid1 |-> res_valid0)
    else $error("result_retire: lane 1 result without lane 0");

endmodule

`default_nettype wire

/* dual_issue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dual_issue_top
  import dual_issue_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        push0,
  input  wire  [INSTR_W-1:0]         in_data0,
  input  wire                        push1,
  input  wire  [INSTR_W-1:0]         in_data1,
  input  wire                        hold,
  output logic                       q_full,
  output logic                       q_1left_to_full,
  output logic                       q_half_full,
  output logic                       q_empty,
  output logic [INSTR_W-1:0]         q_entry0,
  output logic [INSTR_W-1:0]         q_entry1,
  output logic [INSTR_W-1:0]         q_entry2,
  output logic [INSTR_W-1:0]         q_entry3,
  output logic [INSTR_W-1:0]         q_entry4,
  output logic [INSTR_W-1:0]         q_entry5,
  output logic [INSTR_W-1:0]         q_entry6,
  output logic [INSTR_W-1:0]         q_entry7,
  output logic [FIFO_DEPTH_LOG2-1:0] q_head_ptr,
  output logic [7:0]                 q_valid,
  output logic                       ret_valid0,
  output logic [RES_W-1:0]           ret_data0,
  output logic [SEQ_W-1:0]           ret_seq0,
  output logic                       ret_valid1,
  output logic [RES_W-1:0]           ret_data1,
  output logic [SEQ_W-1:0]           ret_seq1
);

  logic [INSTR_W-1:0] head0;
  logic [INSTR_W-1:0] head1;
  logic               pop0;
  logic               pop1;
  logic               one_left;
  logic               dec_valid0;
  logic [OP_W-1:0]    dec_op0;
  logic [OPND_W-1:0]  dec_a0;
  logic [OPND_W-1:0]  dec_b0;
  logic [IMM_W-1:0]   dec_imm0;
  logic [SHAMT_W-1:0] dec_shamt0;
  logic               dec_valid1;
  logic [OP_W-1:0]    dec_op1;
  logic [OPND_W-1:0]  dec_a1;
  logic [OPND_W-1:0]  dec_b1;
  logic [IMM_W-1:0]   dec_imm1;
  logic [SHAMT_W-1:0] dec_shamt1;
  logic               res_valid0;
  logic [RES_W-1:0]   res_data0;
  logic               res_valid1;
  logic [RES_W-1:0]   res_data1;

  open_fifo8_2w2r #(.DWIDTH(INSTR_W)) i_fifo (
    .clk(clk), .rst_n(rst_n),
    .push0(push0), .in_data0(in_data0), .push1(push1), .in_data1(in_data1),
    .pop0(pop0), .pop1(pop1), .out_data0(head0), .out_data1(head1),
    .fifo_half_full(q_half_full), .fifo_full(q_full),
    .fifo_1left_to_full(q_1left_to_full), .fifo_empty(q_empty),
    .fifo_1left_to_empty(one_left),
    .d0(q_entry0), .d1(q_entry1), .d2(q_entry2), .d3(q_entry3),
    .d4(q_entry4), .d5(q_entry5), .d6(q_entry6), .d7(q_entry7),
    .d_ptr(q_head_ptr), .d_valid(q_valid)
  );

  // Three register stages from pop to retire
  issue_decode i_decode (
    .clk(clk), .rst_n(rst_n), .hold(hold),
    .fifo_empty(q_empty), .fifo_1left_to_empty(one_left),
    .head0(head0), .head1(head1), .pop0(pop0), .pop1(pop1),
    .dec_valid0(dec_valid0), .dec_op0(dec_op0), .dec_a0(dec_a0), .dec_b0(dec_b0),
    .dec_imm0(dec_imm0), .dec_shamt0(dec_shamt0),
    .dec_valid1(dec_valid1), .dec_op1(dec_op1), .dec_a1(dec_a1), .dec_b1(dec_b1),
    .dec_imm1(dec_imm1), .dec_shamt1(dec_shamt1)
  );

  alu_execute i_alu (
    .clk(clk), .rst_n(rst_n),
    .dec_valid0(dec_valid0), .dec_op0(dec_op0), .dec_a0(dec_a0), .dec_b0(dec_b0),
    .dec_imm0(dec_imm0), .dec_shamt0(dec_shamt0),
    .dec_valid1(dec_valid1), .dec_op1(dec_op1), .dec_a1(dec_a1), .dec_b1(dec_b1),
    .dec_imm1(dec_imm1), .dec_shamt1(dec_shamt1),
    .res_valid0(res_valid0), .res_data0(res_data0),
    .res_valid1(res_valid1), .res_data1(res_data1)
  );

  result_retire i_retire (
    .clk(clk), .rst_n(rst_n),
    .res_valid0(res_valid0), .res_data0(res_data0),
    .res_valid1(res_valid1), .res_data1(res_data1),
    .ret_valid0(ret_valid0), .ret_data0(ret_data0), .ret_seq0(ret_seq0),
    .ret_valid1(ret_valid1), .ret_data1(ret_data1), .ret_seq1(ret_seq1)
  );

endmodule

`default_nettype wire

/* tb_dual_issue_model.svh */
`ifndef TB_DUAL_ISSUE_MODEL_SVH
`define TB_DUAL_ISSUE_MODEL_SVH

logic [15:0] lfsr_state;
logic [31:0] model_q [$];
logic [15:0] exp_res [$];
logic [7:0]  exp_seq [$];
int          exp_due [$];
logic [7:0]  seq_next;
int          edge_no;
int          pushed_total;
int          retired_total;
// Hold level seen at the last three edges, bit 2 oldest
logic [2:0]  hold_hist;

// 16-bit Galois LFSR
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 16'hB400;
  end
  return n;
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  int          k;
  v = '0;
  for (k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// Expected result from the opcode rules
function automatic logic [15:0] model_alu(input logic [31:0] word);
  instr_u      w;
  logic [15:0] res;
  w = word;
  res = 16'd0;
  if (w.r.op == OP_ADD) begin
    res = {2'b00, 14'(w.r.a + w.r.b)};
  end else if (w.r.op == OP_SUB) begin
    res = {2'b00, 14'(w.r.a - w.r.b)};
  end else if (w.r.op == OP_AND) begin
    res = {2'b00, w.r.a & w.r.b};
  end else if (w.r.op == OP_XOR) begin
    res = {2'b00, w.r.a ^ w.r.b};
  end else if (w.i.op == OP_ADDI) begin
    res = 16'(w.i.a) + 16'(w.i.imm);
  end else if (w.i.op == OP_SHLI) begin
    res = (16'(w.i.a) + 16'(w.i.imm)) << w.i.shamt;
  end
  return res;
endfunction

// Mostly legal opcodes, some arbitrary ones
function automatic logic [31:0] make_word();
  instr_u     w;
  logic [2:0] sel;
  sel = 3'(take_bits(3));
  case (sel)
    3'd0:    w.r.op = OP_ADD;
    3'd1:    w.r.op = OP_SUB;
    3'd2:    w.r.op = OP_AND;
    3'd3:    w.r.op = OP_XOR;
    3'd4:    w.r.op = OP_ADDI;
    3'd5:    w.r.op = OP_SHLI;
    default: w.r.op = 4'(take_bits(4));
  endcase
  w.r.a = 14'(take_bits(14));
  w.r.b = 14'(take_bits(14));
  return w;
endfunction

// Issue rule first on the old count, then the pushes of this edge
task automatic model_edge(input logic p0, input logic p1, input logic [31:0] w0,
                          input logic [31:0] w1, input logic hold_in);
  int          n_pop;
  int          k;
  logic [31:0] w;
  edge_no++;
  n_pop = 0;
  if (!hold_in) begin
    n_pop = (model_q.size() >= 2) ? 2 : model_q.size();
  end
  for (k = 0; k < n_pop; k++) begin
    w = model_q.pop_front();
    exp_res.push_back(model_alu(w));
    exp_seq.push_back(seq_next);
    exp_due.push_back(edge_no + 2);
    seq_next = seq_next + 8'd1;
  end
  if (p0) begin
    model_q.push_back(w0);
    pushed_total++;
  end
  if (p1) begin
    model_q.push_back(w1);
    pushed_total++;
  end
  hold_hist = {hold_hist[1:0], hold_in};
endtask

task automatic retire_front();
  void'(exp_res.pop_front());
  void'(exp_seq.pop_front());
  void'(exp_due.pop_front());
endtask

`endif

/* tb_dual_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dual_issue
  import dual_issue_pkg::*;
();

  logic                       clk;
  logic                       rst_n;
  logic                       push0;
  logic [INSTR_W-1:0]         in_data0;
  logic                       push1;
  logic [INSTR_W-1:0]         in_data1;
  logic                       hold;
  logic                       q_full;
  logic                       q_1left_to_full;
  logic                       q_half_full;
  logic                       q_empty;
  logic [INSTR_W-1:0]         q_entry [8];
  logic [FIFO_DEPTH_LOG2-1:0] q_head_ptr;
  logic [7:0]                 q_valid;
  logic                       ret_valid0;
  logic [RES_W-1:0]           ret_data0;
  logic [SEQ_W-1:0]           ret_seq0;
  logic                       ret_valid1;
  logic [RES_W-1:0]           ret_data1;
  logic [SEQ_W-1:0]           ret_seq1;

  `include "tb_dual_issue_model.svh"

  always #2 clk = ~clk;

  dual_issue_top i_dut (
    .clk(clk), .rst_n(rst_n),
    .push0(push0), .in_data0(in_data0), .push1(push1), .in_data1(in_data1), .hold(hold),
    .q_full(q_full), .q_1left_to_full(q_1left_to_full), .q_half_full(q_half_full),
    .q_empty(q_empty),
    .q_entry0(q_entry[0]), .q_entry1(q_entry[1]), .q_entry2(q_entry[2]),
    .q_entry3(q_entry[3]), .q_entry4(q_entry[4]), .q_entry5(q_entry[5]),
    .q_entry6(q_entry[6]), .q_entry7(q_entry[7]),
    .q_head_ptr(q_head_ptr), .q_valid(q_valid),
    .ret_valid0(ret_valid0), .ret_data0(ret_data0), .ret_seq0(ret_seq0),
    .ret_valid1(ret_valid1), .ret_data1(ret_data1), .ret_seq1(ret_seq1)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v));
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    assert (exp_v === act_v) else report_mismatch(name, exp_v, act_v);
  endtask

  // Space is taken from the count before the edge, pops do not free a slot in time
  task automatic drive_inputs(input logic active);
    int          space;
    int          n_push;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [1:0]  hold_pick;
    space  = 8 - model_q.size();
    n_push = 0;
    hold_pick = 2'b11;
    if (active) begin
      n_push = int'(take_bits(2));
      hold_pick = 2'(take_bits(2));
    end
    if (n_push > 2) begin
      n_push = 2;
    end
    if (n_push > space) begin
      n_push = space;
    end
    w0 = make_word();
    w1 = make_word();
    push0    = (n_push >= 1);
    push1    = (n_push == 2);
    in_data0 = w0;
    in_data1 = w1;
    hold     = (hold_pick == 2'b00);
  endtask

  task automatic check_outputs();
    int count;
    int n_due;
    count = model_q.size();
    n_due = 0;
    check_eq("q_empty", 32'(count == 0), 32'(q_empty));
    check_eq("q_full", 32'(count == 8), 32'(q_full));
    check_eq("q_1left_to_full", 32'(count == 7), 32'(q_1left_to_full));
    check_eq("q_half_full", 32'(count >= 4), 32'(q_half_full));
    check_eq("q_valid_count", 32'(count), 32'($countones(q_valid)));
    if (count > 0) begin
      check_eq("q_head_entry", model_q[0], q_entry[q_head_ptr]);
    end
    while (n_due < exp_due.size() && n_due < 2 && exp_due[n_due] == edge_no) begin
      n_due++;
    end
    assert (!(ret_valid1 && !ret_valid0)) else fail_run("lane 1 retired without lane 0");
    assert (!(hold_hist[2] && ret_valid0))
      else fail_run("result retired more than three cycles after hold rose");
    check_eq("ret_valid0", 32'(n_due >= 1), 32'(ret_valid0));
    check_eq("ret_valid1", 32'(n_due == 2), 32'(ret_valid1));
    retired_total += int'(ret_valid0) + int'(ret_valid1);
    if (n_due >= 1) begin
      check_eq("ret_data0", 32'(exp_res[0]), 32'(ret_data0));
      check_eq("ret_seq0", 32'(exp_seq[0]), 32'(ret_seq0));
      retire_front();
    end
    if (n_due == 2) begin
      check_eq("ret_data1", 32'(exp_res[0]), 32'(ret_data1));
      check_eq("ret_seq1", 32'(exp_seq[0]), 32'(ret_seq1));
      retire_front();
    end
  endtask

  initial begin
    int cyc;
    int drain_cycles;
    clk           = 1'b0;
    rst_n         = 1'b0;
    push0         = 1'b0;
    push1         = 1'b0;
    in_data0      = '0;
    in_data1      = '0;
    hold          = 1'b0;
    lfsr_state    = 16'd17;
    seq_next      = 8'd0;
    edge_no       = 0;
    pushed_total  = 0;
    retired_total = 0;
    hold_hist     = 3'b000;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_eq("reset_empty", 32'd1, 32'(q_empty));
    check_eq("reset_ret_valid", 32'd0, 32'({ret_valid1, ret_valid0}));

    for (cyc = 0; cyc < 3000; cyc++) begin
      drive_inputs(1'b1);
      @(posedge clk);
      model_edge(push0, push1, in_data0, in_data1, hold);
      #1;
      check_outputs();
    end

    // Stop pushing and let everything retire
    drain_cycles = 0;
    while ((model_q.size() > 0 || exp_res.size() > 0) && drain_cycles < 64) begin
      drive_inputs(1'b0);
      @(posedge clk);
      model_edge(push0, push1, in_data0, in_data1, hold);
      #1;
      check_outputs();
      drain_cycles++;
    end

    // Three stages deep, so any stray result shows within three edges
    repeat (3) begin
      drive_inputs(1'b0);
      @(posedge clk);
      #1;
      retired_total += int'(ret_valid0) + int'(ret_valid1);
    end

    if (model_q.size() > 0 || exp_res.size() > 0) begin
      fail_run("timeout: pipeline did not drain within 64 cycles");
    end else if (retired_total == pushed_total) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_mismatch("retire_count", pushed_total, retired_total);
    end
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
dual_issue_pkg.sv
open_fifo4.sv
open_fifo8_2w2r.sv
issue_decode.sv
alu_execute.sv
result_retire.sv
dual_issue_top.sv
tb_dual_issue.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_dual_issue -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation passed"
